//--- filelist.f
+incdir+.
snd_bus_pkg.sv
snd_audio_pkg.sv
snd_chan_if.sv
snd_bus_decode.sv
snd_chan_feed.sv
snd_chan_scale.sv
snd_mix_sum.sv
snd_board.sv
tb_snd_check.sv
tb_snd_board.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the sound board testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -f filelist.f \
        --top-module tb_snd_board -o sim_snd_board \
    && ./obj_dir/sim_snd_board | tee /dev/stderr | grep -q "^TEST RESULT: PASS$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tb_snd_board.sv
// Sound board testbench
`timescale 1ns/100ps

module tb_snd_board;

    typedef struct {
        bit          audio;     // Pulse sample and wait for snd_valid
        bit          rnd;       // Random FM and PCM samples
        logic [7:0]  gid;
        logic [15:0] a;
        logic [4:0]  ctl;       // mreq_n iorq_n m1_n rd_n wr_n
        logic [7:0]  d;
        logic [1:0]  fx;
        logic [1:0]  en;        // enable_fm enable_psg
        logic [15:0] l;
        logic [15:0] r;
        logic [8:0]  p;
    } row_t;

    localparam logic [4:0] MRD = 5'b01101;
    localparam logic [4:0] MWR = 5'b01110;
    localparam logic [4:0] IRD = 5'b10101;
    localparam logic [4:0] IWR = 5'b10110;
    localparam logic [4:0] INTA = 5'b10011;     // Interrupt acknowledge
    localparam logic [4:0] IDLE = 5'b11111;

    logic clk, rst, mreq_n, iorq_n, m1_n, rd_n, wr_n, pcm_busyn, mapper_rd, mapper_wr;
    logic pcm_rst, pcm_mdn, sample, enable_fm, enable_psg, peak, snd_valid;
    logic [7:0] game_id, cpu_dout, fm_dout, ram_dout, mapper_dout, cpu_din;
    logic [15:0] addr;
    logic [18:0] rom_addr;
    logic signed [8:0] pcm_raw;
    logic [1:0] fxlevel;
    snd_bus_pkg::chip_sel_t sel;
    snd_audio_pkg::sample_t fm_left, fm_right, snd;
    int errors;
    int tb_errors = 0;      // Missing snd_valid
    int seed = 32'ha95a8c1f;
    row_t rows[$];
    logic [7:0] latch_val [4] = '{8'h2d, 8'hd4, 8'h48, 8'h03};
    logic [7:0] gids [3] = '{8'h00, 8'h12, 8'h25};  // 5521, 5358, 5797

    snd_board u_dut (.*);
    tb_snd_check u_check (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic add_bus(logic [7:0] gid, logic [15:0] a, logic [4:0] ctl, logic [7:0] d);
        rows.push_back('{0, 0, gid, a, ctl, d, 2'd0, 2'b00, 16'h0, 16'h0, 9'h0});
    endtask

    task automatic add_audio(bit rnd, logic [1:0] fx, logic [1:0] en,
                             logic [15:0] l, logic [15:0] r, logic [8:0] p);
        rows.push_back('{1, rnd, 8'h00, 16'h0000, IDLE, 8'h00, fx, en, l, r, p});
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!snd_valid && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!snd_valid) begin
            tb_errors++;
            $display("No snd_valid within 10 clocks of a sample pulse at %0d ns", $time);
        end
    endtask

    initial begin
        rst = 1'b1;
        {game_id, addr, cpu_dout, fxlevel, enable_fm, enable_psg} = '0;
        {mreq_n, iorq_n, m1_n, rd_n, wr_n} = IDLE;
        fm_dout = 8'h5a;
        ram_dout = 8'ha5;
        mapper_dout = 8'h3c;
        pcm_busyn = 1'b0;
        sample = 1'b0;
        fm_left = '0;
        fm_right = '0;
        pcm_raw = '0;
        // Decode and read mux
        add_bus(8'h00, 16'h8000, MRD, 8'h00);  // Bank with reset msb
        add_bus(8'h00, 16'h0123, MRD, 8'h00);
        add_bus(8'h00, 16'hf900, MRD, 8'h00);
        add_bus(8'h00, 16'he900, MRD, 8'h00);  // Mapper window
        add_bus(8'h00, 16'he7ff, MWR, 8'h00);  // Just below it
        add_bus(8'h00, 16'hefff, MWR, 8'h00);
        add_bus(8'h00, 16'h0001, IRD, 8'h00);
        add_bus(8'h00, 16'h0081, IRD, 8'h00);
        add_bus(8'h00, 16'h0082, IRD, 8'h00);  // Other busy level
        add_bus(8'h00, 16'h00c0, IWR, 8'h11);
        add_bus(8'h00, 16'h0040, INTA, 8'h00);
        // Latch then banked reads on each board type
        foreach (latch_val[j]) begin
            add_bus(8'h00, 16'h0040, IWR, latch_val[j]);
            foreach (gids[k]) add_bus(gids[k], 16'h9abc + 16'(j) * 16'h1000, MRD, 8'h00);
        end
        repeat (6) add_audio(1, 2'd0, 2'b10, 16'h0, 16'h0, 9'h0);     // FM only
        add_audio(0, 2'd0, 2'b00, 16'h1234, 16'h4321, 9'h0);         // All muted
        for (int fx = 0; fx < 4; fx++) begin
            repeat (4) add_audio(1, 2'(fx), 2'b01, 16'h0, 16'h0, 9'h0);
        end
        add_audio(1, 2'd2, 2'b00, 16'h0, 16'h0, 9'h0);
        add_audio(1, 2'd3, 2'b11, 16'h0, 16'h0, 9'h0);
        add_audio(0, 2'd0, 2'b10, 16'h7530, 16'h7530, 9'h0);         // +30000 twice
        add_audio(0, 2'd0, 2'b10, 16'h8ad0, 16'h8ad0, 9'h0);         // -30000 twice
        add_audio(0, 2'd0, 2'b10, 16'h03e8, 16'h07d0, 9'h0);
        repeat (3) @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            @(negedge clk);
            game_id = rows[i].gid;
            addr = rows[i].a;
            {mreq_n, iorq_n, m1_n, rd_n, wr_n} = rows[i].ctl;
            cpu_dout = rows[i].d;
            pcm_busyn = ~pcm_busyn;     // Busy flag alternates per row
            fxlevel = rows[i].fx;
            {enable_fm, enable_psg} = rows[i].en;
            fm_left = rows[i].rnd ? 16'($random(seed)) : rows[i].l;
            fm_right = rows[i].rnd ? 16'($random(seed)) : rows[i].r;
            pcm_raw = rows[i].rnd ? 9'($random(seed)) : rows[i].p;
            if (rows[i].audio) begin
                @(negedge clk);     // Gains registered first
                sample = 1'b1;
                @(negedge clk);
                sample = 1'b0;
                wait_valid();
            end
        end
        repeat (3) @(negedge clk);
        $display("Errors: %0d value, %0d timeout", errors, tb_errors);
        if (errors + tb_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog scaled by the table length
    initial begin
        wait (rst === 1'b0);    // Table is complete by reset release
        #(rows.size() * 2000 + 20000);
        $display("Watchdog expired before the stimulus table finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- tb_snd_check.sv
// Sound board response checker
`timescale 1ns/100ps
`include "snd_consts.svh"

module tb_snd_check (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [7:0]                   game_id,
    input  logic [15:0]                  addr,
    input  logic                         mreq_n,
    input  logic                         iorq_n,
    input  logic                         m1_n,
    input  logic                         rd_n,
    input  logic                         wr_n,
    input  logic [7:0]                   cpu_dout,
    input  logic [7:0]                   fm_dout,
    input  logic [7:0]                   ram_dout,
    input  logic [7:0]                   mapper_dout,
    input  logic                         pcm_busyn,
    input  snd_bus_pkg::chip_sel_t       sel,
    input  logic [18:0]                  rom_addr,
    input  logic [7:0]                   cpu_din,
    input  logic                         mapper_rd,
    input  logic                         mapper_wr,
    input  logic                         pcm_rst,
    input  logic                         pcm_mdn,
    input  logic                         sample,
    input  snd_audio_pkg::sample_t       fm_left,
    input  snd_audio_pkg::sample_t       fm_right,
    input  logic signed [8:0]            pcm_raw,
    input  logic [1:0]                   fxlevel,
    input  logic                         enable_fm,
    input  logic                         enable_psg,
    input  snd_audio_pkg::sample_t       snd,
    input  logic                         peak,
    input  logic                         snd_valid,
    output int                           errors
);

    snd_bus_pkg::chip_sel_t sel_m;      // Expected selects
    logic [18:0]            addr_m;     // Expected ROM address
    logic [5:0]             msb_m = '0; // Bank bits of the latch
    logic                   rst_m = 1'b1;
    logic                   mdn_m = 1'b1;
    logic [7:0]             din_m;
    longint                 y_m;            // Pole filter state
    longint                 gain_m [3];
    longint                 scaled_m [3];
    bit                     strobe_m;
    bit                     valid_m;
    longint                 snd_m;
    bit                     peak_m;

    initial errors = 0;

    function automatic longint wrap9(longint v);
        logic signed [8:0] t;
        t = v[8:0];             // State is only 9 bits wide
        return t;
    endfunction

    task automatic check(string what, longint got, longint exp);
        if (got != exp) begin
            errors++;
            $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Bus decode from the address map
    always_comb begin
        sel_m      = '0;
        sel_m.ram  = !mreq_n && addr[15:11] == 5'h1f;
        sel_m.bank = !mreq_n && addr[15:12] >= 4'h8 && addr[15:12] <= 4'hd;
        sel_m.rom  = sel_m.bank || (!mreq_n && !addr[15]);
        if (!iorq_n && m1_n) begin
            sel_m.fm     = addr[7:6] == 2'd0;
            sel_m.misc   = addr[7:6] == 2'd1;
            sel_m.pcm    = addr[7:6] == 2'd2;
            sel_m.mapper = addr[7:6] == 2'd3;
        end else begin
            sel_m.mapper = !mreq_n && addr >= 16'he800 && addr <= 16'hefff;
        end
        addr_m = {4'b0, addr[14:0]};
        if (sel_m.bank) begin
            if (game_id[7:5] == 3'b001) begin
                addr_m[18:14] = {msb_m[3], msb_m[4], msb_m[2], msb_m[1], msb_m[0]};
            end else if (game_id[7:4] == 4'b0001) begin
                addr_m[15:14] = msb_m[1:0];
                addr_m[17:16] = msb_m[5] ? 2'd3 : msb_m[4] ? 2'd2 : msb_m[3] ? 2'd1 : 2'd0;
            end else begin
                addr_m[17:14] = msb_m[3:0];
            end
        end
        addr_m = addr_m + `SND_ROM_OFFSET;
    end

    always @(posedge clk) begin
        longint sum;
        // Read mux in priority order
        if (sel_m.rom) din_m = 8'hff;       // ROM data comes from off-board
        else if (sel_m.ram) din_m = ram_dout;
        else if (sel_m.fm) din_m = fm_dout;
        else if (sel_m.pcm) din_m = {pcm_busyn, 7'h7f};
        else if (sel_m.mapper) din_m = mapper_dout;
        else din_m = 8'hff;
        if (rst) begin
            msb_m    = '0;
            rst_m    = 1'b1;
            mdn_m    = 1'b1;
            y_m      = 0;
            gain_m   = '{0, 0, 0};
            scaled_m = '{0, 0, 0};
            strobe_m = 0;
            valid_m  = 0;
            snd_m    = 0;
            peak_m   = 0;
        end else begin
            // Oldest stage first so each sees last clock's state
            if (strobe_m) begin
                sum    = scaled_m[0] + scaled_m[1] + scaled_m[2];
                peak_m = sum > 32767 || sum < -32768;
                snd_m  = sum > 32767 ? 32767 : (sum < -32768 ? -32768 : sum);
            end
            valid_m  = strobe_m;
            strobe_m = sample;
            if (sample) begin
                scaled_m[0] = (longint'(fm_left) * gain_m[0]) >>> 4;
                scaled_m[1] = (longint'(fm_right) * gain_m[1]) >>> 4;
                scaled_m[2] = (y_m * 128 * gain_m[2]) >>> 4;   // Old state feeds mixer
                y_m = wrap9(y_m + (((longint'(pcm_raw) - y_m) * (16 - `SND_POLE_A)) >>> 4));
            end
            gain_m[0] = enable_fm ? `SND_FM_GAIN : 0;
            gain_m[1] = gain_m[0];
            gain_m[2] = enable_psg ? (4 << fxlevel) : 0;   // 1/4 up to x2
            if (sel_m.misc && !wr_n) begin
                msb_m = cpu_dout[5:0];
                rst_m = !cpu_dout[6];
                mdn_m = !cpu_dout[7];
            end
        end
        #25;    // Mid high phase with outputs settled
        check("sel", sel, sel_m);
        check("rom_addr", rom_addr, addr_m);
        check("mapper_rd", mapper_rd, sel_m.mapper && !rd_n);
        check("mapper_wr", mapper_wr, sel_m.mapper && !wr_n);
        check("pcm_rst", pcm_rst, rst_m);
        check("pcm_mdn", pcm_mdn, mdn_m);
        check("cpu_din", cpu_din, din_m);
        check("snd", snd, snd_m);
        check("peak", peak, peak_m);
        check("snd_valid", snd_valid, valid_m);
    end

endmodule

//--- snd_board.sv
// Sound board glue top
`timescale 1ns/100ps
`include "snd_consts.svh"

module snd_board (
    input  logic                          clk,
    input  logic                          rst,
    // Sound CPU bus
    input  logic [7:0]                    game_id,
    input  logic [`SND_AW-1:0]            addr,
    input  logic                          mreq_n,
    input  logic                          iorq_n,
    input  logic                          m1_n,
    input  logic                          rd_n,
    input  logic                          wr_n,
    input  logic [`SND_DW-1:0]            cpu_dout,
    input  logic [`SND_DW-1:0]            fm_dout,
    input  logic [`SND_DW-1:0]            ram_dout,
    input  logic [`SND_DW-1:0]            mapper_dout,
    input  logic                          pcm_busyn,
    output snd_bus_pkg::chip_sel_t        sel,
    output logic [`SND_ROM_AW-1:0]        rom_addr,
    output logic [`SND_DW-1:0]            cpu_din,
    output logic                          mapper_rd,
    output logic                          mapper_wr,
    output logic                          pcm_rst,
    output logic                          pcm_mdn,
    // Audio sources
    input  logic                          sample,
    input  snd_audio_pkg::sample_t        fm_left,
    input  snd_audio_pkg::sample_t        fm_right,
    input  logic signed [`SND_PCM_W-1:0]  pcm_raw,
    input  logic [1:0]                    fxlevel,
    input  logic                          enable_fm,
    input  logic                          enable_psg,
    // Mixed output
    output snd_audio_pkg::sample_t        snd,
    output logic                          peak,
    output logic                          snd_valid
);

    snd_chan_if ch [`SND_NCHAN] ();    // 0 FM L, 1 FM R, 2 PCM

    snd_bus_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .game_id     (game_id),
        .addr        (addr),
        .mreq_n      (mreq_n),
        .iorq_n      (iorq_n),
        .m1_n        (m1_n),
        .rd_n        (rd_n),
        .wr_n        (wr_n),
        .cpu_dout    (cpu_dout),
        .fm_dout     (fm_dout),
        .ram_dout    (ram_dout),
        .mapper_dout (mapper_dout),
        .pcm_busyn   (pcm_busyn),
        .sel         (sel),
        .rom_addr    (rom_addr),
        .cpu_din     (cpu_din),
        .mapper_rd   (mapper_rd),
        .mapper_wr   (mapper_wr),
        .pcm_rst     (pcm_rst),
        .pcm_mdn     (pcm_mdn)
    );

    snd_chan_feed u_feed (
        .clk        (clk),
        .rst        (rst),
        .sample     (sample),
        .fm_left    (fm_left),
        .fm_right   (fm_right),
        .pcm_raw    (pcm_raw),
        .fxlevel    (fxlevel),
        .enable_fm  (enable_fm),
        .enable_psg (enable_psg),
        .ch         (ch)
    );

    // One multiplier per channel
    for (genvar i = 0; i < `SND_NCHAN; i++) begin : g_scale
        snd_chan_scale u_scale (
            .clk (clk),
            .rst (rst),
            .ch  (ch[i])
        );
    end

    snd_mix_sum #(
        .NCH (`SND_NCHAN)
    ) u_mix (
        .clk       (clk),
        .rst       (rst),
        .ch        (ch),
        .snd       (snd),
        .peak      (peak),
        .snd_valid (snd_valid)
    );

endmodule

//--- snd_mix_sum.sv
// Channel sum and clamp
`timescale 1ns/100ps

module snd_mix_sum #(
    parameter int NCH = 3
) (
    input  logic                    clk,
    input  logic                    rst,
    snd_chan_if.drain               ch [NCH],
    output snd_audio_pkg::sample_t  snd,
    output logic                    peak,
    output logic                    snd_valid
);

    localparam int SW = $bits(snd_audio_pkg::scaled_t) + $clog2(NCH) + 1;
    localparam logic signed [SW-1:0] SMAX = 32767;
    localparam logic signed [SW-1:0] SMIN = -32768;

    snd_audio_pkg::scaled_t scaled_v [NCH];
    logic [NCH-1:0]         strobe_v;
    logic                   strobe_d;   // Scalers have loaded
    logic signed [SW-1:0]   sum;
    logic signed [SW-1:0]   clamped;
    logic                   over;

    for (genvar i = 0; i < NCH; i++) begin : g_tap
        assign scaled_v[i] = ch[i].scaled;
        assign strobe_v[i] = ch[i].strobe;
    end

    always_comb begin
        sum = '0;
        for (int i = 0; i < NCH; i++) begin
            sum = sum + SW'(scaled_v[i]);   // Sign-extended
        end
        over    = 1'b1;
        clamped = sum;
        if (sum > SMAX) begin
            clamped = SMAX;
        end else if (sum < SMIN) begin
            clamped = SMIN;
        end else begin
            over = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            strobe_d  <= 1'b0;
            snd       <= '0;
            peak      <= 1'b0;
            snd_valid <= 1'b0;
        end else begin
            strobe_d  <= |strobe_v;
            snd_valid <= strobe_d;
            if (strobe_d) begin
                snd  <= snd_audio_pkg::sample_t'(clamped);
                peak <= over;           // Per sample, not sticky
            end
        end
    end

endmodule

//--- snd_chan_scale.sv
// Channel gain stage
`timescale 1ns/100ps

module snd_chan_scale (
    input  logic        clk,
    input  logic        rst,
    snd_chan_if.chan    ch
);

    logic signed [24:0] prod;   // 16 x 9 signed

    // Gain is unsigned, so a zero sign bit goes in front
    assign prod = ch.in_sample * $signed({1'b0, ch.gain});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ch.scaled <= '0;
        end else if (ch.strobe) begin
            ch.scaled <= snd_audio_pkg::scaled_t'(prod >>> 4);  // 4.4 fraction out
        end
    end

endmodule

//--- snd_chan_feed.sv
// Mixer channel feeder
`timescale 1ns/100ps
`include "snd_consts.svh"

module snd_chan_feed (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          sample,     // FM sample pulse
    input  snd_audio_pkg::sample_t        fm_left,
    input  snd_audio_pkg::sample_t        fm_right,
    input  logic signed [`SND_PCM_W-1:0]  pcm_raw,
    input  logic [1:0]                    fxlevel,
    input  logic                          enable_fm,
    input  logic                          enable_psg,
    snd_chan_if.feed                      ch [`SND_NCHAN]
);

    localparam int POLE_B = 16 - `SND_POLE_A;  // Weight of the new input

    snd_audio_pkg::gain_t                 fm_gain;
    snd_audio_pkg::gain_t                 pcm_gain;
    logic signed [`SND_PCM_W-1:0]         y;          // Filter state
    logic signed [`SND_PCM_W:0]           diff;       // One extra bit
    logic signed [15:0]                   prod;
    logic signed [15:0]                   step;

    // Gains, refreshed every clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fm_gain  <= '0;
            pcm_gain <= '0;
        end else begin
            fm_gain <= enable_fm ? `SND_FM_GAIN : 8'h00;
            case (fxlevel)
                2'd0: pcm_gain <= 8'h04;   // 1/4
                2'd1: pcm_gain <= 8'h08;   // 1/2
                2'd2: pcm_gain <= 8'h10;
                2'd3: pcm_gain <= 8'h20;   // x2
            endcase
            if (!enable_psg) begin
                pcm_gain <= 8'h00;          // PCM muted
            end
        end
    end

    // One-pole low-pass, y += (x - y) * (1 - a)
    always_comb begin
        diff = (`SND_PCM_W+1)'(pcm_raw) - (`SND_PCM_W+1)'(y);
        prod = diff * $signed(6'(POLE_B));
        step = prod >>> 4;      // Drop the 4-bit fraction
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            y <= '0;
        end else if (sample) begin
            y <= y + `SND_PCM_W'(step);
        end
    end

    // Channel loading
    assign ch[0].in_sample = fm_left;
    assign ch[0].gain      = fm_gain;
    assign ch[1].in_sample = fm_right;
    assign ch[1].gain      = fm_gain;
    assign ch[2].in_sample = {y, 7'd0};     // 9 bits up to full scale
    assign ch[2].gain      = pcm_gain;

    for (genvar i = 0; i < `SND_NCHAN; i++) begin : g_strobe
        assign ch[i].strobe = sample;       // Common sample rate
    end

endmodule

//--- snd_bus_decode.sv
// Sound CPU bus decoder
`timescale 1ns/100ps
`include "snd_consts.svh"

module snd_bus_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [7:0]                game_id,
    input  logic [`SND_AW-1:0]        addr,
    input  logic                      mreq_n,
    input  logic                      iorq_n,
    input  logic                      m1_n,
    input  logic                      rd_n,
    input  logic                      wr_n,
    input  logic [`SND_DW-1:0]        cpu_dout,
    input  logic [`SND_DW-1:0]        fm_dout,
    input  logic [`SND_DW-1:0]        ram_dout,
    input  logic [`SND_DW-1:0]        mapper_dout,
    input  logic                      pcm_busyn,
    output snd_bus_pkg::chip_sel_t    sel,
    output logic [`SND_ROM_AW-1:0]    rom_addr,
    output logic [`SND_DW-1:0]        cpu_din,
    output logic                      mapper_rd,
    output logic                      mapper_wr,
    output logic                      pcm_rst,
    output logic                      pcm_mdn
);

    snd_bus_pkg::board_t       board;
    logic [5:0]                rom_msb;     // Bank bits from the latch
    logic [`SND_ROM_AW-1:0]    bank_addr;   // Before the ROM offset
    logic                      io_cycle;

    assign io_cycle = !iorq_n && m1_n;  // Skip interrupt acknowledge

    // Board variant from the game code
    always_comb begin
        if (game_id[7:5] == 3'b001) begin
            board = snd_bus_pkg::B5797;
        end else if (game_id[7:4] == 4'b0001) begin
            board = snd_bus_pkg::B5358;
        end else begin
            board = snd_bus_pkg::B5521;
        end
    end

    // Chip selects
    always_comb begin
        sel      = '0;
        sel.ram  = !mreq_n && (&addr[15:11]);                      // F800 up
        sel.bank = !mreq_n && addr[15:12] >= 4'h8 && addr[15:12] <= 4'hd;
        sel.rom  = (!mreq_n && !addr[15]) || sel.bank;
        if (io_cycle) begin
            case (addr[7:6])    // Port map on A7:A6
                2'd0: sel.fm     = 1'b1;
                2'd1: sel.misc   = 1'b1;
                2'd2: sel.pcm    = 1'b1;
                2'd3: sel.mapper = 1'b1;
            endcase
        end else begin
            sel.mapper = !mreq_n && addr[15:11] == 5'b11101;   // E800-EFFF
        end
    end

    assign mapper_rd = sel.mapper && !rd_n;
    assign mapper_wr = sel.mapper && !wr_n;

    // Banked ROM address
    always_comb begin
        bank_addr = `SND_ROM_AW'(addr[14:0]);
        if (sel.bank) begin
            case (board)
                snd_bus_pkg::B5797: begin
                    bank_addr[18:14] = {rom_msb[3], rom_msb[4], rom_msb[2:0]};
                end
                snd_bus_pkg::B5358: begin
                    bank_addr[15:14] = rom_msb[1:0];
                    // Highest set bit of msb5:2, msb2 gives 0
                    if (rom_msb[5]) begin
                        bank_addr[17:16] = 2'd3;
                    end else if (rom_msb[4]) begin
                        bank_addr[17:16] = 2'd2;
                    end else if (rom_msb[3]) begin
                        bank_addr[17:16] = 2'd1;
                    end else begin
                        bank_addr[17:16] = 2'd0;    // msb2 or none
                    end
                end
                default: begin
                    bank_addr[17:14] = rom_msb[3:0];
                end
            endcase
        end
    end

    assign rom_addr = bank_addr + `SND_ROM_OFFSET;

    // Read data back to the CPU, one clock late
    always_ff @(posedge clk) begin
        if (sel.rom) begin
            cpu_din <= 8'hff;       // ROM data is served off-board
        end else if (sel.ram) begin
            cpu_din <= ram_dout;
        end else if (sel.fm) begin
            cpu_din <= fm_dout;
        end else if (sel.pcm) begin
            cpu_din <= {pcm_busyn, 7'h7f};     // Busy flag on D7
        end else if (sel.mapper) begin
            cpu_din <= mapper_dout;
        end else begin
            cpu_din <= 8'hff;       // Open bus
        end
    end

    // Control latch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_msb <= 6'd0;
            pcm_rst <= 1'b1;    // PCM held in reset
            pcm_mdn <= 1'b1;    // Stand-alone mode
        end else if (sel.misc && !wr_n) begin
            rom_msb <= cpu_dout[5:0];
            pcm_rst <= ~cpu_dout[6];
            pcm_mdn <= ~cpu_dout[7];
        end
    end

endmodule

//--- snd_chan_if.sv
// Mixer channel link
`timescale 1ns/100ps

interface snd_chan_if;
    snd_audio_pkg::sample_t in_sample;  // Channel input
    snd_audio_pkg::gain_t   gain;       // Registered gain
    logic                   strobe;     // FM sample pulse
    snd_audio_pkg::scaled_t scaled;     // Gain-scaled sample

    // Source side, loads samples and gains
    modport feed (
        output in_sample,
        output gain,
        output strobe
    );

    // Per-channel multiplier
    modport chan (
        input  in_sample,
        input  gain,
        input  strobe,
        output scaled
    );

    // Summing stage
    modport drain (
        input  scaled,
        input  strobe
    );
endinterface

//--- snd_audio_pkg.sv
// Audio path types
package snd_audio_pkg;

    // Channel sample as seen by the mixer
    typedef logic signed [15:0] sample_t;

    // 4.4 fixed point, 8'h10 is unity
    typedef logic [7:0] gain_t;

    // Sample times gain after dropping the fraction
    typedef logic signed [23:0] scaled_t;

endpackage

//--- snd_bus_pkg.sv
// Sound CPU bus types
package snd_bus_pkg;

    // Sound board variants, picked from game_id
    typedef enum logic [7:0] {
        B5521,  // Also covers 5704
        B5358,  // Priority-encoded upper bank
        B5797   // Swapped msb3/msb4
    } board_t;

    // One flag per decoded device
    typedef struct packed {
        logic rom;      // Fixed or banked ROM
        logic ram;      // F800-FFFF
        logic bank;     // 8000-DFFF window
        logic fm;       // YM2151 port
        logic pcm;      // uPD7759 port
        logic misc;     // Control latch
        logic mapper;   // Main-board mapper
    } chip_sel_t;

endpackage

//--- snd_consts.svh
// Sound board constants
`ifndef SND_CONSTS_SVH
`define SND_CONSTS_SVH

// Mixer layout
`define SND_NCHAN       3       // FM left, FM right, PCM

// Gains in 4.4 fixed point
`define SND_FM_GAIN     8'h10   // Unity

// One-pole low-pass on the PCM channel
`define SND_POLE_A      10      // a = 10/16, about 4kHz

// Sound ROM map
`define SND_ROM_AW      19
`define SND_ROM_OFFSET  19'h10000   // Sound ROM sits above the main code

// CPU bus widths
`define SND_AW          16
`define SND_DW          8

// Raw PCM width from the ADPCM chip
`define SND_PCM_W       9

`endif
